// File: design/dcache_pkg.sv
/*
 * shared widths, data types and controller states for the
 * two-way write-back data cache
 */
package dcache_pkg;

    // bus and word geometry
    localparam int ADDR_W   = 64;
    localparam int WORD_W   = 64;
    localparam int MASK_W   = WORD_W / 8;
    localparam int OFFSET_W = 3;

    // default number of set index bits, 64 sets
    localparam int DEF_INDEX_W = 6;

    // byte address and data word
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // bit n enables byte n of a word
    typedef logic [MASK_W-1:0] mask_t;

    // replacement age, saturates at AGE_MAX
    typedef logic [2:0] age_t;
    localparam age_t AGE_MAX = 3'd7;

    // way number, two ways
    typedef logic way_t;

    // cache controller FSM
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WBACK,
        REFILL,
        MERGE
    } ctrl_state_e;

endpackage

// File: design/way_ctrl_if.sv
/*
 * way control bus between the cache controller and the
 * tag, data and replacement stores
 */
interface way_ctrl_if #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W;

    // from the controller
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    dcache_pkg::way_t    sel_way;
    logic                fill_en;
    logic                store_en;
    logic                touch_en;
    logic                dirty_set;
    logic                dirty_clr;
    dcache_pkg::word_t   wdata;
    dcache_pkg::mask_t   wmask;

    // from the tag store
    logic                hit;
    dcache_pkg::way_t    hit_way;
    logic [1:0]          way_valid;
    logic [TAG_W-1:0]    sel_tag;

    // from the replacement store
    dcache_pkg::way_t    victim_way;
    logic                victim_dirty;

    // from the data store
    dcache_pkg::word_t   rdata;

    modport ctrl (
        output index, tag, sel_way, fill_en, store_en, touch_en,
               dirty_set, dirty_clr, wdata, wmask,
        input  hit, hit_way, way_valid, sel_tag, victim_way, victim_dirty, rdata
    );

    modport tags (
        input  index, tag, sel_way, fill_en,
        output hit, hit_way, way_valid, sel_tag
    );

    modport data (
        input  index, sel_way, fill_en, store_en, wdata, wmask,
        output rdata
    );

    modport repl (
        input  index, sel_way, touch_en, dirty_set, dirty_clr, way_valid,
        output victim_way, victim_dirty
    );

endinterface

// File: design/dcache_tag_store.sv
/*
 * tag store: valid bit and tag per set and way,
 * combinational compare of both ways against the request tag
 */
module dcache_tag_store #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic        clk,
    input  logic        rst,
    way_ctrl_if.tags    bus
);

    localparam int SETS  = 2 ** INDEX_W;
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W;

    logic [1:0]       valid_q [SETS];
    logic [TAG_W-1:0] tag_q   [SETS][2];

    logic [1:0]       match;

    // per-way compare on the selected set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid_q[bus.index][w] && (tag_q[bus.index][w] == bus.tag);
        end
    end

    assign bus.hit       = |match;
    // way 1 only when way 0 misses
    assign bus.hit_way   = match[0] ? 1'b0 : 1'b1;
    assign bus.way_valid = valid_q[bus.index];
    assign bus.sel_tag   = tag_q[bus.index][bus.sel_way];

    // install on refill
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s]  <= '0;
                tag_q[s][0] <= '0;
                tag_q[s][1] <= '0;
            end
        end else if (bus.fill_en) begin
            valid_q[bus.index][bus.sel_way] <= 1'b1;
            tag_q[bus.index][bus.sel_way]   <= bus.tag;
        end
    end

endmodule

// File: design/dcache_data_store.sv
/*
 * data store: one word per set and way, registered read
 * of the selected way, full-word fill and byte-masked store
 */
module dcache_data_store #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic        clk,
    way_ctrl_if.data    bus
);

    localparam int SETS = 2 ** INDEX_W;

    dcache_pkg::word_t line_q [SETS][2];
    dcache_pkg::word_t rdata_q;

    // write port
    always_ff @(posedge clk) begin
        if (bus.fill_en) begin
            line_q[bus.index][bus.sel_way] <= bus.wdata;
        end else if (bus.store_en) begin
            for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
                if (bus.wmask[b]) begin
                    line_q[bus.index][bus.sel_way][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        rdata_q <= line_q[bus.index][bus.sel_way];
    end

    assign bus.rdata = rdata_q;

endmodule

// File: design/dcache_replace.sv
/*
 * replacement store: saturating age counters and dirty bits
 * per set and way, picks the victim of a miss
 */
module dcache_replace #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic        clk,
    input  logic        rst,
    way_ctrl_if.repl    bus
);

    localparam int SETS = 2 ** INDEX_W;

    dcache_pkg::age_t age_q   [SETS][2];
    logic [1:0]       dirty_q [SETS];

    dcache_pkg::age_t age0;
    dcache_pkg::age_t age1;
    dcache_pkg::way_t other_way;
    dcache_pkg::way_t victim;

    assign age0      = age_q[bus.index][0];
    assign age1      = age_q[bus.index][1];
    assign other_way = ~bus.sel_way;

    // invalid ways first, then the older way, tie goes to way 0
    always_comb begin
        if (!bus.way_valid[0]) begin
            victim = 1'b0;
        end else if (!bus.way_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = (age1 > age0) ? 1'b1 : 1'b0;
        end
    end

    assign bus.victim_way   = victim;
    assign bus.victim_dirty = dirty_q[bus.index][victim];

    // ages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                age_q[s][0] <= '0;
                age_q[s][1] <= '0;
            end
        end else if (bus.touch_en) begin
            age_q[bus.index][bus.sel_way] <= '0;
            // other way grows older until it saturates
            if (age_q[bus.index][other_way] != dcache_pkg::AGE_MAX) begin
                age_q[bus.index][other_way] <= age_q[bus.index][other_way] + 3'd1;
            end
        end
    end

    // dirty bits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                dirty_q[s] <= '0;
            end
        end else if (bus.dirty_set) begin
            dirty_q[bus.index][bus.sel_way] <= 1'b1;
        end else if (bus.dirty_clr) begin
            dirty_q[bus.index][bus.sel_way] <= 1'b0;
        end
    end

endmodule

// File: design/dcache_ctrl.sv
/*
 * cache controller: latches the CPU request, runs lookup,
 * hit, write-back, refill and merge, drives the memory strobes
 */
module dcache_ctrl #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_rd_i,
    input  logic                cpu_wr_i,
    input  dcache_pkg::addr_t   cpu_addr_i,
    input  dcache_pkg::word_t   cpu_wdata_i,
    input  dcache_pkg::mask_t   cpu_mask_i,
    output dcache_pkg::word_t   cpu_rdata_o,
    output logic                cpu_done_o,
    output logic                mem_rd_o,
    output logic                mem_wr_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::word_t   mem_wdata_o,
    input  dcache_pkg::word_t   mem_rdata_i,
    input  logic                mem_ok_i,
    way_ctrl_if.ctrl            bus
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W;

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    logic                    done_q;

    // latched request
    logic [INDEX_W-1:0]      index_q;
    logic [TAG_W-1:0]        tag_q;
    dcache_pkg::word_t       wdata_q;
    dcache_pkg::mask_t       mask_q;
    logic                    is_load_q;
    dcache_pkg::way_t        way_q;

    logic                    req;
    logic                    need_wb;
    logic                    fill;

    // a request is not taken in the cycle after done
    assign req     = (cpu_rd_i || cpu_wr_i) && !done_q;
    assign need_wb = bus.way_valid[bus.victim_way] && bus.victim_dirty;
    assign fill    = (state_q == dcache_pkg::REFILL) && mem_ok_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (req) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (bus.hit) begin
                    state_d = dcache_pkg::HIT;
                end else if (need_wb) begin
                    state_d = dcache_pkg::WBACK;
                end else begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::HIT: begin
                state_d = dcache_pkg::IDLE;
            end
            dcache_pkg::WBACK: begin
                if (mem_ok_i) begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (mem_ok_i) begin
                    state_d = is_load_q ? dcache_pkg::IDLE : dcache_pkg::MERGE;
                end
            end
            dcache_pkg::MERGE: begin
                state_d = dcache_pkg::IDLE;
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= dcache_pkg::IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= cpu_done_o;
        end
    end

    // request capture, read wins over write
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && req) begin
            index_q   <= cpu_addr_i[dcache_pkg::OFFSET_W +: INDEX_W];
            tag_q     <= cpu_addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];
            wdata_q   <= cpu_wdata_i;
            mask_q    <= cpu_mask_i;
            is_load_q <= cpu_rd_i;
        end
        // hit way or victim, held for the rest of the access
        if (state_q == dcache_pkg::LOOKUP) begin
            way_q <= bus.hit ? bus.hit_way : bus.victim_way;
        end
    end

    // way bus
    assign bus.index     = index_q;
    assign bus.tag       = tag_q;
    assign bus.sel_way   = (state_q == dcache_pkg::LOOKUP)
                           ? (bus.hit ? bus.hit_way : bus.victim_way) : way_q;
    assign bus.fill_en   = fill;
    assign bus.store_en  = ((state_q == dcache_pkg::HIT) && !is_load_q)
                           || (state_q == dcache_pkg::MERGE);
    assign bus.touch_en  = cpu_done_o;
    assign bus.dirty_set = bus.store_en;
    assign bus.dirty_clr = fill;
    // refill word during refill, CPU data otherwise
    assign bus.wdata     = (state_q == dcache_pkg::REFILL) ? mem_rdata_i : wdata_q;
    assign bus.wmask     = mask_q;

    // CPU side
    assign cpu_done_o  = (state_q == dcache_pkg::HIT) || (state_q == dcache_pkg::MERGE)
                         || (fill && is_load_q);
    assign cpu_rdata_o = (state_q == dcache_pkg::REFILL) ? mem_rdata_i : bus.rdata;

    // memory side, victim address on write-back
    assign mem_rd_o    = (state_q == dcache_pkg::REFILL);
    assign mem_wr_o    = (state_q == dcache_pkg::WBACK);
    assign mem_addr_o  = mem_wr_o
                         ? {bus.sel_tag, index_q, {dcache_pkg::OFFSET_W{1'b0}}}
                         : {tag_q, index_q, {dcache_pkg::OFFSET_W{1'b0}}};
    assign mem_wdata_o = bus.rdata;

endmodule

// File: design/dcache_top.sv
/*
 * two-way write-back data cache, top level
 * CPU load/store port on one side, word-wide memory port on the other
 */
module dcache_top #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic                clk,
    input  logic                rst,
    // CPU port
    input  logic                cpu_rd_i,
    input  logic                cpu_wr_i,
    input  dcache_pkg::addr_t   cpu_addr_i,
    input  dcache_pkg::word_t   cpu_wdata_i,
    input  dcache_pkg::mask_t   cpu_mask_i,
    output dcache_pkg::word_t   cpu_rdata_o,
    output logic                cpu_done_o,
    // memory port
    output logic                mem_rd_o,
    output logic                mem_wr_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::word_t   mem_wdata_o,
    input  dcache_pkg::word_t   mem_rdata_i,
    input  logic                mem_ok_i
);

    way_ctrl_if #(.INDEX_W(INDEX_W)) way_bus ();

    dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_rd_i    (cpu_rd_i),
        .cpu_wr_i    (cpu_wr_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_mask_i  (cpu_mask_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_done_o  (cpu_done_o),
        .mem_rd_o    (mem_rd_o),
        .mem_wr_o    (mem_wr_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ok_i    (mem_ok_i),
        .bus         (way_bus)
    );

    dcache_tag_store #(.INDEX_W(INDEX_W)) u_tags (
        .clk (clk),
        .rst (rst),
        .bus (way_bus)
    );

    dcache_data_store #(.INDEX_W(INDEX_W)) u_data (
        .clk (clk),
        .bus (way_bus)
    );

    dcache_replace #(.INDEX_W(INDEX_W)) u_repl (
        .clk (clk),
        .rst (rst),
        .bus (way_bus)
    );

endmodule

// File: verification/tb_dcache.sv
/*
 * testbench for the two-way write-back data cache
 * memory model with random latency, shadow memory, replacement model
 */
module tb_dcache;

    localparam int IDX_W = 6;
    localparam int SETS  = 2 ** IDX_W;
    localparam int OFF_W = dcache_pkg::OFFSET_W;
    localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - OFF_W;
    localparam logic [31:0] SEED = 32'h0ced_3635;

    logic clk;
    logic rst;
    logic cpu_rd_i;
    logic cpu_wr_i;
    dcache_pkg::addr_t cpu_addr_i;
    dcache_pkg::word_t cpu_wdata_i;
    dcache_pkg::mask_t cpu_mask_i;
    dcache_pkg::word_t cpu_rdata_o;
    logic cpu_done_o;
    logic mem_rd_o;
    logic mem_wr_o;
    dcache_pkg::addr_t mem_addr_o;
    dcache_pkg::word_t mem_wdata_o;
    dcache_pkg::word_t mem_rdata_i;
    logic mem_ok_i;

    // memory contents and the data the CPU should see
    dcache_pkg::word_t mem [dcache_pkg::addr_t];
    dcache_pkg::word_t shadow [dcache_pkg::addr_t];
    int rd_count = 0;
    int wb_count = 0;
    dcache_pkg::addr_t last_wb_addr;
    dcache_pkg::word_t last_wb_data;
    logic [31:0] stim_rng = SEED;
    logic [31:0] mem_rng = ~SEED;

    // replacement model
    logic             m_valid [SETS][2];
    logic             m_dirty [SETS][2];
    logic [TAG_W-1:0] m_tag   [SETS][2];
    dcache_pkg::age_t m_age   [SETS][2];

    dcache_top #(.INDEX_W(IDX_W)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = lcg(stim_rng);
        return stim_rng;
    endfunction

    // power-up contents hashed from the full address
    function automatic dcache_pkg::word_t mem_init(input dcache_pkg::addr_t a);
        logic [31:0] h;
        h = lcg(SEED ^ a[31:0] ^ lcg(a[63:32]));
        return {h, lcg(h)};
    endfunction

    function automatic dcache_pkg::addr_t word_addr(input dcache_pkg::addr_t a);
        return {a[dcache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    endfunction

    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::addr_t a);
        if (shadow.exists(word_addr(a))) begin
            return shadow[word_addr(a)];
        end
        return mem_init(word_addr(a));
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input logic [31:0] t,
                                                    input logic [IDX_W-1:0] s);
        logic [TAG_W-1:0] tg;
        tg = '0;
        tg[31:0] = t;
        tg[TAG_W-1 -: 8] = t[7:0];
        return {tg, s, 3'b010};
    endfunction

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t got,
                              input dcache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // memory side answers after 1 to 6 cycles
    initial begin : mem_model
        int dly;
        logic is_wr;
        mem_ok_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            mem_ok_i = 1'b0;
            if (mem_rd_o || mem_wr_o) begin
                is_wr = mem_wr_o;
                mem_rng = lcg(mem_rng);
                dly = 1 + int'((mem_rng >> 16) % 32'd6);
                repeat (dly) @(negedge clk);
                if (is_wr) begin
                    mem[mem_addr_o] = mem_wdata_o;
                    last_wb_addr = mem_addr_o;
                    last_wb_data = mem_wdata_o;
                    wb_count++;
                end else begin
                    mem_rdata_i = mem.exists(mem_addr_o) ? mem[mem_addr_o]
                                                         : mem_init(mem_addr_o);
                    rd_count++;
                end
                mem_ok_i = 1'b1;
            end
        end
    end

    // hit or miss plus victim and write-back by the age rule
    task automatic model_access(input dcache_pkg::addr_t a, input logic is_store,
                                output logic hit, output logic wb,
                                output dcache_pkg::addr_t wb_addr);
        logic [IDX_W-1:0] s;
        logic [TAG_W-1:0] t;
        int w;
        s = a[OFF_W +: IDX_W];
        t = a[dcache_pkg::ADDR_W-1 -: TAG_W];
        hit = 1'b0;
        wb = 1'b0;
        wb_addr = '0;
        w = 0;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                hit = 1'b1;
                w = i;
            end
        end
        if (!hit) begin
            if (!m_valid[s][0]) w = 0;
            else if (!m_valid[s][1]) w = 1;
            else w = (m_age[s][1] > m_age[s][0]) ? 1 : 0;
            wb = m_valid[s][w] && m_dirty[s][w];
            wb_addr = {m_tag[s][w], s, {OFF_W{1'b0}}};
            m_valid[s][w] = 1'b1;
            m_tag[s][w] = t;
            m_dirty[s][w] = 1'b0;
        end
        if (is_store) m_dirty[s][w] = 1'b1;
        m_age[s][w] = '0;
        if (m_age[s][1-w] != dcache_pkg::AGE_MAX) m_age[s][1-w] = m_age[s][1-w] + 3'd1;
    endtask

    task automatic cpu_access(input logic is_store, input dcache_pkg::addr_t a,
                              input dcache_pkg::word_t wd, input dcache_pkg::mask_t m,
                              output dcache_pkg::word_t rd, output int cycles);
        cycles = 1;
        @(negedge clk);
        cpu_rd_i = !is_store;
        cpu_wr_i = is_store;
        cpu_addr_i = a;
        cpu_wdata_i = wd;
        cpu_mask_i = m;
        #10;
        while (!cpu_done_o) begin
            if (cycles >= 200) begin
                $display("timeout: no cpu_done_o within 200 cycles of a request");
                stop_run();
            end
            @(negedge clk);
            #10;
            cycles++;
        end
        rd = cpu_rdata_o;
        @(negedge clk);
        cpu_rd_i = 1'b0;
        cpu_wr_i = 1'b0;
    endtask

    task automatic run_access(input logic is_store, input dcache_pkg::addr_t a,
                              input dcache_pkg::word_t wd, input dcache_pkg::mask_t m);
        logic hit;
        logic wb;
        dcache_pkg::addr_t wb_addr;
        dcache_pkg::word_t exp;
        dcache_pkg::word_t victim;
        dcache_pkg::word_t rd;
        int cycles;
        int rd0;
        int wb0;
        model_access(a, is_store, hit, wb, wb_addr);
        exp = expected_load(a);
        victim = expected_load(wb_addr);
        rd0 = rd_count;
        wb0 = wb_count;
        cpu_access(is_store, a, wd, m, rd, cycles);
        if (is_store) begin
            for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
                if (m[b]) exp[8*b +: 8] = wd[8*b +: 8];
            end
            shadow[word_addr(a)] = exp;
        end else begin
            check_word("cpu_rdata_o", rd, exp);
        end
        check_count("memory reads", rd_count - rd0, hit ? 0 : 1);
        check_count("write-backs", wb_count - wb0, wb ? 1 : 0);
        if (wb) begin
            check_addr("mem_addr_o on write-back", last_wb_addr, wb_addr);
            check_word("mem_wdata_o", last_wb_data, victim);
        end
        if (hit) check_count("hit latency in cycles", cycles, 3);
    endtask

    initial begin : stimulus
        dcache_pkg::addr_t a;
        logic [31:0] r;
        int wb_base;
        rst = 1'b0;
        cpu_rd_i = 1'b0;
        cpu_wr_i = 1'b0;
        cpu_addr_i = '0;
        cpu_wdata_i = '0;
        cpu_mask_i = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_age[s][w] = '0;
            end
        end
        // reset and idle outputs
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (i == 3) rst = 1'b1;
            #10;
            check_count("cpu_done_o", int'(cpu_done_o), 0);
            check_count("mem_rd_o", int'(mem_rd_o), 0);
            check_count("mem_wr_o", int'(mem_wr_o), 0);
        end
        // load miss, then hit
        a = make_addr(32'd1, 6'd5);
        run_access(1'b0, a, '0, '0);
        run_access(1'b0, a, '0, '0);
        // masked store hits
        run_access(1'b1, a, 64'h1122_3344_5566_7788, 8'hA5);
        run_access(1'b0, a, '0, '0);
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            run_access(1'b1, a, {next_rand(), next_rand()}, r[23:16]);
            run_access(1'b0, a, '0, '0);
        end
        // store miss with write-allocate
        a = make_addr(32'd2, 6'd9);
        run_access(1'b1, a, 64'hcafe_f00d_0bad_beef, 8'h3C);
        run_access(1'b0, a, '0, '0);
        // dirty way 0 of set 20 is evicted by a third tag
        run_access(1'b1, make_addr(32'd3, 6'd20), 64'h0123_4567_89ab_cdef, 8'hFF);
        run_access(1'b0, make_addr(32'd4, 6'd20), '0, '0);
        wb_base = wb_count;
        run_access(1'b0, make_addr(32'd5, 6'd20), '0, '0);
        check_count("write-backs from set 20", wb_count - wb_base, 1);
        check_addr("evicted line address", last_wb_addr, word_addr(make_addr(32'd3, 6'd20)));
        run_access(1'b0, make_addr(32'd3, 6'd20), '0, '0);
        // random mix over sets 40 to 43 and six tags
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            a = make_addr(32'd100 + {29'd0, r[18:16] % 3'd6}, {4'b1010, r[21:20]});
            run_access(r[24], a, {next_rand(), next_rand()}, r[7:0]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: sources.f
design/dcache_pkg.sv
design/way_ctrl_if.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_replace.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_dcache -f sources.f -Mdir obj_dir \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_dcache 2>&1 | tee sim.log
grep -q "Verification failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
